// ==== logic/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam int xlen = 32;

    // major opcodes seen by fetch
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // B-type immediate layout
    typedef struct packed {
        logic       sign;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fields_t;

    // J-type immediate layout
    typedef struct packed {
        logic       sign;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fields_t;

    // one fetched word, read through either immediate view
    typedef union packed {
        logic [xlen-1:0] raw;
        b_fields_t       b;
        j_fields_t       j;
    } instr_u;

endpackage

`default_nettype wire

// ==== logic/predict_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface predict_if #(
    parameter int pred_index_bits = 4
) ();

    logic [pred_index_bits-1:0] lookup_index;
    logic                       predict_taken;  // answered in the same cycle

    logic                       update_valid;   // one-cycle strobe
    logic [pred_index_bits-1:0] update_index;
    logic                       update_taken;

    modport fetch (
        output lookup_index, update_valid, update_index, update_taken,
        input  predict_taken
    );

    modport predictor (
        input  lookup_index, update_valid, update_index, update_taken,
        output predict_taken
    );

endinterface

`default_nettype wire

// ==== logic/branch_predictor.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_predictor #(
    parameter int pred_index_bits = 4
) (
    input  logic          clk,
    input  logic          reset_n,
    predict_if.predictor  pred
);

    localparam int entries = 1 << pred_index_bits;

    // counter msb is the prediction
    localparam logic [1:0] strong_not_taken = 2'd0;
    localparam logic [1:0] weak_not_taken   = 2'd1;
    localparam logic [1:0] strong_taken     = 2'd3;

    logic [1:0] counters [entries];
    logic [1:0] cur_count;
    logic [1:0] new_count;

    assign pred.predict_taken = counters[pred.lookup_index][1];

    assign cur_count = counters[pred.update_index];

    // one step toward the resolved direction
    always_comb begin
        new_count = cur_count;
        if (pred.update_taken) begin
            if (cur_count != strong_taken) begin
                new_count = cur_count + 2'd1;
            end
        end else begin
            if (cur_count != strong_not_taken) begin
                new_count = cur_count - 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < entries; i++) begin
                counters[i] <= weak_not_taken;
            end
        end else if (pred.update_valid) begin
            counters[pred.update_index] <= new_count;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_pc_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_unit #(
    parameter int pred_index_bits = 4
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  fetch_pkg::instr_u          instr,
    input  logic                       hold,
    input  logic                       resolve_valid,
    input  logic                       resolve_taken,
    input  logic                       resolve_jalr,
    input  logic [fetch_pkg::xlen-1:0] jalr_offset,
    predict_if.fetch                   pred,
    output logic [fetch_pkg::xlen-1:0] address,
    output logic                       if_id_flush,
    output logic                       id_ex_flush
);

    localparam int xlen = fetch_pkg::xlen;

    // jalr travels as kind other
    localparam logic [1:0] kind_other = 2'd0;
    localparam logic [1:0] kind_cond  = 2'd1;
    localparam logic [1:0] kind_jal   = 2'd2;

    localparam logic [xlen-1:0] instr_bytes = 4;

    logic            fetch_step;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] b_offset;
    logic [xlen-1:0] j_offset;
    logic [xlen-1:0] fetch_offset;
    logic [1:0]      fetch_kind;
    logic            fetch_pred;

    logic [xlen-1:0] s1_pc;
    logic [xlen-1:0] s1_offset;
    logic [1:0]      s1_kind;
    logic            s1_pred;
    logic [xlen-1:0] s2_pc;
    logic [xlen-1:0] s2_offset;
    logic [1:0]      s2_kind;
    logic            s2_pred;

    logic            mispredict;
    logic [xlen-1:0] resolve_target;

    assign fetch_step = !hold;

    // sign-extended offsets from both views of one word
    assign b_offset = {{19{instr.b.sign}}, instr.b.sign, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign j_offset = {{11{instr.j.sign}}, instr.j.sign, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    always_comb begin
        if (instr.b.opcode == fetch_pkg::opcode_branch) begin
            fetch_kind   = kind_cond;
            fetch_offset = b_offset;
            fetch_pred   = pred.predict_taken;
        end else if (instr.j.opcode == fetch_pkg::opcode_jal) begin
            fetch_kind   = kind_jal;
            fetch_offset = j_offset;
            fetch_pred   = 1'b1;  // jal always goes
        end else begin
            fetch_kind   = kind_other;
            fetch_offset = '0;
            fetch_pred   = 1'b0;
        end
    end

    // stage 2 is being resolved by execute
    assign mispredict = resolve_valid && (resolve_taken != s2_pred);

    always_comb begin
        if (resolve_taken) begin
            resolve_target = s2_pc + (resolve_jalr ? jalr_offset : s2_offset);
        end else begin
            resolve_target = s2_pc + instr_bytes;  // fall through
        end
    end

    always_comb begin
        if (mispredict) begin
            pc_next = resolve_target;
        end else if (fetch_kind == kind_jal) begin
            pc_next = pc + j_offset;
        end else if (fetch_kind == kind_cond && fetch_pred) begin
            pc_next = pc + b_offset;
        end else begin
            pc_next = pc + instr_bytes;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= fetch_pkg::reset_pc;
        end else if (fetch_step) begin
            pc <= pc_next;
        end
    end

    // both wrong-path entries die on a mispredict
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_kind <= kind_other;
            s1_pred <= 1'b0;
            s2_kind <= kind_other;
            s2_pred <= 1'b0;
        end else if (fetch_step) begin
            if (mispredict) begin
                s1_kind <= kind_other;
                s1_pred <= 1'b0;
                s2_kind <= kind_other;
                s2_pred <= 1'b0;
            end else begin
                s1_kind <= fetch_kind;
                s1_pred <= fetch_pred;
                s2_kind <= s1_kind;
                s2_pred <= s1_pred;
            end
        end
    end

    // record payload
    always_ff @(posedge clk) begin
        if (fetch_step) begin
            s1_pc     <= pc;
            s1_offset <= fetch_offset;
            s2_pc     <= s1_pc;
            s2_offset <= s1_offset;
        end
    end

    assign pred.lookup_index = pc[pred_index_bits+1:2];
    assign pred.update_valid = resolve_valid && fetch_step && (s2_kind == kind_cond);
    assign pred.update_index = s2_pc[pred_index_bits+1:2];
    assign pred.update_taken = resolve_taken;

    assign address     = pc;
    assign if_id_flush = mispredict;
    assign id_ex_flush = mispredict;

endmodule

`default_nettype wire

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
    parameter int pred_index_bits = 4
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic [fetch_pkg::xlen-1:0] instr,   // word at address, same cycle
    input  logic                       hold,
    input  logic                       resolve_valid,
    input  logic                       resolve_taken,
    input  logic                       resolve_jalr,
    input  logic [fetch_pkg::xlen-1:0] jalr_offset,
    output logic [fetch_pkg::xlen-1:0] address,
    output logic                       if_id_flush,
    output logic                       id_ex_flush
);

    fetch_pkg::instr_u instr_word;

    assign instr_word = instr;

    // lookup and update path between pc unit and counters
    predict_if #(
        .pred_index_bits (pred_index_bits)
    ) pred_bus ();

    fetch_pc_unit #(
        .pred_index_bits (pred_index_bits)
    ) i_pc_unit (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr         (instr_word),
        .hold          (hold),
        .resolve_valid (resolve_valid),
        .resolve_taken (resolve_taken),
        .resolve_jalr  (resolve_jalr),
        .jalr_offset   (jalr_offset),
        .pred          (pred_bus.fetch),
        .address       (address),
        .if_id_flush   (if_id_flush),
        .id_ex_flush   (id_ex_flush)
    );

    branch_predictor #(
        .pred_index_bits (pred_index_bits)
    ) i_predictor (
        .clk     (clk),
        .reset_n (reset_n),
        .pred    (pred_bus.predictor)
    );

endmodule

`default_nettype wire

// ==== verif/fetch_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;

    localparam int index_bits     = 4;
    localparam int test_cycles    = 2000;
    localparam int timeout_cycles = test_cycles + test_cycles / 2;  // margin for reset
    localparam int entries        = 1 << index_bits;

    localparam logic [1:0] kind_other = 2'd0;
    localparam logic [1:0] kind_cond  = 2'd1;
    localparam logic [1:0] kind_jal   = 2'd2;
    localparam logic [6:0] opcode_jalr = 7'b1100111;

    logic        clk;
    logic        reset_n;
    logic [31:0] instr;
    logic        hold;
    logic        resolve_valid;
    logic        resolve_taken;
    logic        resolve_jalr;
    logic [31:0] jalr_offset;
    logic [31:0] address;
    logic        if_id_flush;
    logic        id_ex_flush;

    // reference model state
    logic [31:0] m_pc;
    logic [31:0] s1_pc, s2_pc;
    logic [31:0] s1_off, s2_off;
    logic [1:0]  s1_kind, s2_kind;
    logic        s1_pred, s2_pred;
    logic        s1_jalr, s2_jalr;     // "other" record that execute sees as jalr
    logic [1:0]  counters [entries];
    logic        word_jalr;
    logic [15:0] lfsr_state;

    fetch_top #(
        .pred_index_bits (index_bits)
    ) i_dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr         (instr),
        .hold          (hold),
        .resolve_valid (resolve_valid),
        .resolve_taken (resolve_taken),
        .resolve_jalr  (resolve_jalr),
        .jalr_offset   (jalr_offset),
        .address       (address),
        .if_id_flush   (if_id_flush),
        .id_ex_flush   (id_ex_flush)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 16,14,13,11
    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] result;
        result = '0;
        for (int i = 0; i < n; i++) begin
            result = {result[30:0], next_lfsr_bit()};
        end
        return result;
    endfunction

    // word aligned offset within about 128 bytes
    function automatic logic [31:0] small_offset();
        logic [5:0] r;
        r = random_bits(6);
        return {{24{r[5]}}, r, 2'b00};
    endfunction

    function automatic logic [31:0] b_imm(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] j_imm(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            $display("Something failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // plays instruction memory for the current address
    task automatic make_word();
        logic [2:0]  pick;
        logic [31:0] w;
        logic [31:0] off;
        pick      = random_bits(3);
        w         = random_bits(32);
        off       = small_offset();
        word_jalr = 1'b0;
        if (pick == 3 || pick == 4 || pick == 7) begin
            w[31]    = off[12];
            w[7]     = off[11];
            w[30:25] = off[10:5];
            w[11:8]  = off[4:1];
            w[6:0]   = fetch_pkg::opcode_branch;
        end else if (pick == 5) begin
            w[31]    = off[20];
            w[30:21] = off[10:1];
            w[20]    = off[11];
            w[19:12] = off[19:12];
            w[6:0]   = fetch_pkg::opcode_jal;
        end else if (pick == 6) begin
            w[6:0]    = opcode_jalr;
            word_jalr = 1'b1;
        end else if (w[6:0] == fetch_pkg::opcode_branch || w[6:0] == fetch_pkg::opcode_jal ||
                     w[6:0] == opcode_jalr) begin
            w[6:0] = 7'b0010011;  // plain alu op
        end
        instr = w;
    endtask

    // one fetch step of the model
    task automatic advance_model();
        logic [1:0]  f_kind;
        logic [31:0] f_off;
        logic        f_pred;
        logic        mis;
        logic [31:0] next_pc;
        logic [index_bits-1:0] upd;
        f_kind = kind_other;
        f_off  = '0;
        f_pred = 1'b0;
        if (instr[6:0] == fetch_pkg::opcode_branch) begin
            f_kind = kind_cond;
            f_off  = b_imm(instr);
            f_pred = counters[m_pc[index_bits+1:2]][1];  // before this cycle's update
        end else if (instr[6:0] == fetch_pkg::opcode_jal) begin
            f_kind = kind_jal;
            f_off  = j_imm(instr);
            f_pred = 1'b1;
        end
        mis = resolve_valid && (resolve_taken != s2_pred);
        if (resolve_valid && s2_kind == kind_cond) begin
            upd = s2_pc[index_bits+1:2];
            if (resolve_taken && counters[upd] != 2'd3) begin
                counters[upd] = counters[upd] + 2'd1;
            end else if (!resolve_taken && counters[upd] != 2'd0) begin
                counters[upd] = counters[upd] - 2'd1;
            end
        end
        if (mis) begin
            next_pc = resolve_taken ? s2_pc + (s2_jalr ? jalr_offset : s2_off) : s2_pc + 4;
        end else if (f_kind == kind_jal || (f_kind == kind_cond && f_pred)) begin
            next_pc = m_pc + f_off;
        end else begin
            next_pc = m_pc + 4;
        end
        if (mis) begin  // wrong path squashed
            s1_kind = kind_other;
            s1_pred = 1'b0;
            s1_jalr = 1'b0;
            s2_kind = kind_other;
            s2_pred = 1'b0;
            s2_jalr = 1'b0;
        end else begin
            s2_pc   = s1_pc;
            s2_off  = s1_off;
            s2_kind = s1_kind;
            s2_pred = s1_pred;
            s2_jalr = s1_jalr;
            s1_pc   = m_pc;
            s1_off  = f_off;
            s1_kind = f_kind;
            s1_pred = f_pred;
            s1_jalr = word_jalr;
        end
        m_pc = next_pc;
    endtask

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic resolve_due;
        logic hold_now;
        logic have_word;
        logic exp_flush;
        reset_n       = 1'b0;
        instr         = '0;
        hold          = 1'b0;
        resolve_valid = 1'b0;
        resolve_taken = 1'b0;
        resolve_jalr  = 1'b0;
        jalr_offset   = '0;
        lfsr_state    = 16'd12;
        word_jalr     = 1'b0;
        have_word     = 1'b0;
        m_pc          = fetch_pkg::reset_pc;
        {s1_pc, s2_pc, s1_off, s2_off} = '0;
        {s1_kind, s2_kind, s1_pred, s2_pred, s1_jalr, s2_jalr} = '0;
        for (int i = 0; i < entries; i++) begin
            counters[i] = 2'd1;  // weakly not taken
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        for (int cyc = 0; cyc < test_cycles; cyc++) begin
            resolve_due = (s2_kind != kind_other) || s2_jalr;
            if (!have_word) begin
                make_word();
                have_word = 1'b1;
            end
            hold_now = 1'b0;
            if (!resolve_due && random_bits(3) == 0) begin
                hold_now = 1'b1;  // no resolve may be due while holding
            end
            hold          = hold_now;
            resolve_valid = resolve_due;
            resolve_jalr  = resolve_due && s2_jalr;
            resolve_taken = (s2_kind == kind_cond) ? random_bits(1) : resolve_due;
            jalr_offset   = s2_jalr ? small_offset() : '0;
            #1;
            exp_flush = resolve_due && (resolve_taken != s2_pred);
            check_value("address", address, m_pc);
            check_value("if_id_flush", if_id_flush, exp_flush);
            check_value("id_ex_flush", id_ex_flush, exp_flush);
            if (!hold_now) begin
                advance_model();
                have_word = 1'b0;
            end
            @(negedge clk);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/fetch_pkg.sv
logic/predict_if.sv
logic/branch_predictor.sv
logic/fetch_pc_unit.sv
logic/fetch_top.sv
verif/fetch_tb.sv
